// File: vsaCore.f
logic/vsaPkg.sv
logic/fetchUnit.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/memoryWriteback.sv
logic/vsaCore.sv
tb/vsaChecker.sv
tb/vsaTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = vsaTb
FILELIST = vsaCore.f
OBJDIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

// File: tb/vsaTb.sv
// testbench top for the multicycle core
// random program in a ROM, data RAM, clock, reset, DUT and checker
module vsaTb;
    import vsaPkg::*;

    localparam int romWords  = 256;
    localparam int ramWords  = 256;
    localparam int randCount = 120;     // random instructions ahead of the store block
    localparam int maxCycles = 5000;    // 5 cycles per instruction, generous margin

    logic                 clock;
    logic                 rstN;
    logic [pcWidth-1:0]   pc;
    logic [dataWidth-1:0] instruction;
    logic [dataWidth-1:0] dataAddr;
    logic [dataWidth-1:0] dataIn;
    logic [dataWidth-1:0] dataOut;
    logic                 wr;

    logic [dataWidth-1:0] rom [0:romWords-1];
    logic [dataWidth-1:0] ram [0:ramWords-1];
    logic [pcWidth-1:0]   haltPc;       // address of the branch-to-self
    logic                 done;
    int                   pcErrors;
    int                   storeErrors;
    int                   loadErrors;
    int                   timeouts;
    int                   waited;
    integer               seed;

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // both memories read combinationally, half-word pc
    assign instruction = rom[pc[8:1]];
    assign dataIn      = ram[dataAddr[7:0]];

    always @(posedge clock) begin
        if (wr) begin
            ram[dataAddr[7:0]] <= dataOut;
        end
    end

    vsaCore dut0 (
        .clock, .rstN,
        .pc, .instruction,
        .dataAddr, .dataIn, .dataOut,
        .wr
    );

    vsaChecker check0 (
        .clock, .rstN,
        .pc, .instruction,
        .dataAddr, .dataIn, .dataOut,
        .wr,
        .haltPc,
        .done,
        .pcErrors, .storeErrors, .loadErrors
    );

    // random legal instructions, then stores of R0..R3, then a halt loop
    task automatic loadProgram();
        instrT word;
        int    kind;
        int    idx;
        for (idx = 0; idx < randCount; idx++) begin
            word = '0;
            kind = $unsigned($random(seed)) % 8;
            case (kind)
                0, 1, 2: begin
                    word.rFormat.opcode = opAlu;
                    word.rFormat.src1   = 2'($random(seed));
                    word.rFormat.src2   = 2'($random(seed));
                    word.rFormat.dest   = 2'($random(seed));    // R0 included
                    word.rFormat.func   = 7'($unsigned($random(seed)) % 6);
                end
                3, 4: begin
                    word.iFormat.opcode = (kind == 3) ? opAddi : opSubi;
                    word.iFormat.src1   = 2'($random(seed));
                    word.iFormat.dest   = 2'($random(seed));
                    word.iFormat.imm    = 9'($random(seed));    // negative half the time
                end
                5, 6: begin
                    word.iFormat.opcode = (kind == 5) ? opLw : opSw;
                    // mostly R0 based so loads hit earlier stores
                    word.iFormat.src1 = (($unsigned($random(seed)) % 4) == 0) ?
                                        2'($random(seed)) : 2'd0;
                    word.iFormat.dest = 2'($random(seed));
                    word.iFormat.imm  = 9'($unsigned($random(seed)) % 16);
                end
                default: begin
                    word.iFormat.opcode = opBeqz;
                    word.iFormat.src1   = 2'($random(seed));
                    word.iFormat.imm    = 9'($unsigned($random(seed)) % 4);  // forward only
                end
            endcase
            rom[idx] = word;
        end
        for (idx = 0; idx < 4; idx++) begin
            word = '0;
            word.iFormat.opcode = opSw;
            word.iFormat.dest   = 2'(idx);        // data register
            word.iFormat.imm    = 9'(240 + idx);
            rom[randCount + idx] = word;
        end
        word = '0;
        word.iFormat.opcode = opBeqz;             // R0 is zero, target is itself
        word.iFormat.imm    = 9'h1ff;
        rom[randCount + 4] = word;
        haltPc = 12'((randCount + 4) * pcStep);
    endtask

    initial begin
        rstN     <= 1'b0;
        seed     = 32'h242f_6ed7;
        timeouts = 0;
        for (int i = 0; i < romWords; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < ramWords; i++) begin
            ram[i] <= {8'(i) ^ 8'hc3, 8'(i)};   // address-unique fill
        end
        loadProgram();

        repeat (2) @(posedge clock);
        rstN <= 1'b1;

        for (waited = 0; waited < maxCycles && !done; waited++) begin
            @(posedge clock);
        end
        if (!done) begin
            $display("timeout: the core did not reach the halt loop within %0d cycles",
                     maxCycles);
            timeouts++;
        end
        repeat (5) @(posedge clock);           // one more pass through the halt loop

        $display("errors: pc %0d, store %0d, load %0d, timeout %0d",
                 pcErrors, storeErrors, loadErrors, timeouts);
        if (pcErrors + storeErrors + loadErrors + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb/vsaChecker.sv
// reference model and comparator for the core
// steps an instruction-level model and checks pc, store strobes and loads
module vsaChecker (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic [vsaPkg::pcWidth-1:0]   pc,
    input  logic [vsaPkg::dataWidth-1:0] instruction,
    input  logic [vsaPkg::dataWidth-1:0] dataAddr,
    input  logic [vsaPkg::dataWidth-1:0] dataIn,
    input  logic [vsaPkg::dataWidth-1:0] dataOut,
    input  logic                         wr,
    input  logic [vsaPkg::pcWidth-1:0]   haltPc,
    output logic                         done,
    output int                           pcErrors,
    output int                           storeErrors,
    output int                           loadErrors
);
    import vsaPkg::*;

    logic [pcWidth-1:0]   modelPc;
    logic [dataWidth-1:0] modelRegs [0:3];
    logic [dataWidth-1:0] shadowMem [0:255];     // last stored value per RAM word
    logic                 shadowValid [0:255];
    instrT                fetched;               // word taken in the fetch cycle
    int                   cycleCount;            // cycles since reset release

    function automatic logic [dataWidth-1:0] signExt(input logic [8:0] imm);
        return dataWidth'($signed(imm));
    endfunction

    function void writeModelReg(input logic [1:0] idx, input logic [dataWidth-1:0] value);
        if (idx != 2'd0) begin       // R0 stays zero
            modelRegs[idx] = value;
        end
    endfunction

    // architectural effect of one instruction on the model state
    function void stepInstr(input instrT ir, input logic [dataWidth-1:0] loadWord);
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [pcWidth-1:0]   seqPc;
        a       = modelRegs[ir.iFormat.src1];
        b       = modelRegs[ir.rFormat.src2];
        seqPc   = modelPc + 12'd2;
        modelPc = seqPc;
        case (ir.iFormat.opcode)
            opAlu: begin
                case (ir.rFormat.func)
                    fnAdd:   writeModelReg(ir.rFormat.dest, a + b);
                    fnSub:   writeModelReg(ir.rFormat.dest, a - b);
                    fnAnd:   writeModelReg(ir.rFormat.dest, a & b);
                    fnOr:    writeModelReg(ir.rFormat.dest, a | b);
                    fnXor:   writeModelReg(ir.rFormat.dest, a ^ b);
                    fnSrl:   writeModelReg(ir.rFormat.dest, a >> 1);
                    default: ;       // never generated
                endcase
            end
            opAddi: writeModelReg(ir.iFormat.dest, a + signExt(ir.iFormat.imm));
            opSubi: writeModelReg(ir.iFormat.dest, a - signExt(ir.iFormat.imm));
            opLw:   writeModelReg(ir.iFormat.dest, loadWord);
            opBeqz: begin
                if (a == '0) begin   // word offset from the next pc, 12-bit wrap
                    modelPc = seqPc + 12'(signExt(ir.iFormat.imm) << 1);
                end
            end
            default: ;               // SW leaves registers alone
        endcase
    endfunction

    // outputs settle after the rising edge, compare on the falling one
    always @(negedge clock) begin
        int                   slot;
        logic [dataWidth-1:0] expAddr;
        logic [7:0]           ramIdx;
        if (!rstN) begin
            modelPc     = '0;
            cycleCount  = 0;
            done        = 1'b0;
            pcErrors    = 0;
            storeErrors = 0;
            loadErrors  = 0;
            fetched     = '0;
            for (int i = 0; i < 4; i++) begin
                modelRegs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                shadowValid[i] = 1'b0;
                shadowMem[i]   = '0;
            end
        end else begin
            slot = cycleCount % 5;
            if (pc !== modelPc) begin
                $display("[FAIL] %0t pc %h, expected %h", $time, pc, modelPc);
                pcErrors++;
            end
            if (slot == 0) begin
                fetched = instruction;
                if (modelPc == haltPc) begin
                    done = 1'b1;
                end
            end
            if (slot == 3) begin
                expAddr = modelRegs[fetched.iFormat.src1] + signExt(fetched.iFormat.imm);
                ramIdx  = expAddr[7:0];
                if (fetched.iFormat.opcode == opSw) begin
                    if (wr !== 1'b1) begin
                        $display("[FAIL] %0t wr low in the memory phase of a store", $time);
                        storeErrors++;
                    end
                    if (dataAddr !== expAddr) begin
                        $display("[FAIL] %0t store address %h, expected %h",
                                 $time, dataAddr, expAddr);
                        storeErrors++;
                    end
                    if (dataOut !== modelRegs[fetched.iFormat.dest]) begin
                        $display("[FAIL] %0t store data %h, expected %h",
                                 $time, dataOut, modelRegs[fetched.iFormat.dest]);
                        storeErrors++;
                    end
                    shadowMem[ramIdx]   = modelRegs[fetched.iFormat.dest];
                    shadowValid[ramIdx] = 1'b1;
                end else if (wr !== 1'b0) begin
                    $display("[FAIL] %0t wr high for a non-store", $time);
                    storeErrors++;
                end
                if (fetched.iFormat.opcode == opLw) begin
                    if (dataAddr !== expAddr) begin
                        $display("[FAIL] %0t load address %h, expected %h",
                                 $time, dataAddr, expAddr);
                        loadErrors++;
                    end
                    if (shadowValid[ramIdx] && dataIn !== shadowMem[ramIdx]) begin
                        $display("[FAIL] %0t load data %h, expected %h",
                                 $time, dataIn, shadowMem[ramIdx]);
                        loadErrors++;
                    end
                end
                stepInstr(fetched, dataIn);    // pc moves at the end of this cycle
            end else if (wr !== 1'b0) begin
                $display("[FAIL] %0t wr high outside the memory phase", $time);
                storeErrors++;
            end
            cycleCount++;
        end
    end

endmodule

// File: logic/vsaCore.sv
// top level of the multicycle core
// fetch, register file, execute and memory/write-back wired to the memory ports
module vsaCore (
    input  logic                         clock,
    input  logic                         rstN,
    output logic [vsaPkg::pcWidth-1:0]   pc,            // instruction memory address
    input  logic [vsaPkg::dataWidth-1:0] instruction,
    output logic [vsaPkg::dataWidth-1:0] dataAddr,      // data memory address
    input  logic [vsaPkg::dataWidth-1:0] dataIn,
    output logic [vsaPkg::dataWidth-1:0] dataOut,
    output logic                         wr
);
    import vsaPkg::*;

    phaseT                   phase;
    instrT                   instr;
    logic [pcWidth-1:0]      nextPc;
    logic                    takeBranch;
    logic [pcWidth-1:0]      branchTarget;
    logic [regAddrWidth-1:0] readAddrA;
    logic [regAddrWidth-1:0] readAddrB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;
    logic                    writeEn;
    logic [regAddrWidth-1:0] writeAddr;
    logic [dataWidth-1:0]    writeData;

    fetchUnit fetch0 (
        .clock, .rstN,
        .takeBranch, .branchTarget,
        .instruction,
        .phase, .pc, .nextPc, .instr
    );

    registerFile regs0 (
        .clock, .rstN,
        .readAddrA, .readAddrB,
        .readDataA, .readDataB,
        .writeEn, .writeAddr, .writeData
    );

    // ALU result doubles as the data address, operand B as store data
    executeUnit exec0 (
        .clock, .rstN,
        .phase, .instr, .nextPc,
        .readAddrA, .readAddrB,
        .readDataA, .readDataB,
        .aluResult(dataAddr),
        .storeData(dataOut),
        .takeBranch, .branchTarget
    );

    memoryWriteback memWb0 (
        .clock, .rstN,
        .phase, .instr,
        .aluResult(dataAddr),
        .dataIn,
        .wr,
        .writeEn, .writeAddr, .writeData
    );

endmodule

// File: logic/memoryWriteback.sv
// memory access and write-back stage
// store strobe, load data capture and register write selection
module memoryWriteback (
    input  logic                            clock,
    input  logic                            rstN,
    input  vsaPkg::phaseT                   phase,
    input  vsaPkg::instrT                   instr,
    input  logic [vsaPkg::dataWidth-1:0]    aluResult,
    input  logic [vsaPkg::dataWidth-1:0]    dataIn,
    output logic                            wr,
    output logic                            writeEn,
    output logic [vsaPkg::regAddrWidth-1:0] writeAddr,
    output logic [vsaPkg::dataWidth-1:0]    writeData
);
    import vsaPkg::*;

    logic [dataWidth-1:0] loadData;  // LMD
    logic [2:0]           opcode;

    assign opcode = instr.rFormat.opcode;

    // high for the whole memory cycle of a store
    assign wr = (phase == phaseMemory) && (opcode == opSw);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            loadData <= '0;
        end else if (phase == phaseMemory && opcode == opLw) begin
            loadData <= dataIn;     // memory reads combinationally
        end
    end

    // destination and value depend on format
    always_comb begin
        writeEn   = 1'b0;
        writeAddr = instr.iFormat.dest;    // I-format default
        writeData = aluResult;
        if (phase == phaseWriteback) begin
            case (opcode)
                opAlu: begin
                    writeEn   = 1'b1;
                    writeAddr = instr.rFormat.dest;
                end
                opAddi, opSubi: begin
                    writeEn = 1'b1;
                end
                opLw: begin
                    writeEn   = 1'b1;
                    writeData = loadData;
                end
                default: ;                 // SW, BEQZ write nothing
            endcase
        end
    end

endmodule

// File: logic/executeUnit.sv
// execute stage, operand latches, ALU and branch resolution
// A/B latched in decode, result, condition and target registered in execute
module executeUnit (
    input  logic                            clock,
    input  logic                            rstN,
    input  vsaPkg::phaseT                   phase,
    input  vsaPkg::instrT                   instr,
    input  logic [vsaPkg::pcWidth-1:0]      nextPc,
    output logic [vsaPkg::regAddrWidth-1:0] readAddrA,
    output logic [vsaPkg::regAddrWidth-1:0] readAddrB,
    input  logic [vsaPkg::dataWidth-1:0]    readDataA,
    input  logic [vsaPkg::dataWidth-1:0]    readDataB,
    output logic [vsaPkg::dataWidth-1:0]    aluResult,
    output logic [vsaPkg::dataWidth-1:0]    storeData,
    output logic                            takeBranch,
    output logic [vsaPkg::pcWidth-1:0]      branchTarget
);
    import vsaPkg::*;

    logic [dataWidth-1:0] opA;       // first ALU operand
    logic [dataWidth-1:0] opB;       // second operand, also store data
    logic [dataWidth-1:0] immExt;    // sign-extended immediate
    logic [2:0]           opcode;
    logic [6:0]           func;

    assign opcode = instr.rFormat.opcode;
    assign func   = instr.rFormat.func;
    assign immExt = {{(dataWidth - 9){instr.iFormat.imm[8]}}, instr.iFormat.imm};

    // src2 shares its bits with the I-format dest, so SW reads its data reg here
    assign readAddrA = instr.rFormat.src1;
    assign readAddrB = instr.rFormat.src2;
    assign storeData = opB;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            opA        <= '0;
            opB        <= '0;
            takeBranch <= 1'b0;
        end else begin
            if (phase == phaseDecode) begin
                opA <= readDataA;
                opB <= readDataB;
            end
            if (phase == phaseExecute) begin
                takeBranch <= (opcode == opBeqz) && (opA == '0);  // BEQZ zero test
            end
        end
    end

    // datapath results, held when nothing matches
    always_ff @(posedge clock) begin
        if (phase == phaseExecute) begin
            case (opcode)
                opLw, opSw: aluResult <= opA + immExt;     // effective address
                opAlu: begin
                    case (func)
                        fnAdd:   aluResult <= opA + opB;
                        fnSub:   aluResult <= opA - opB;
                        fnAnd:   aluResult <= opA & opB;
                        fnOr:    aluResult <= opA | opB;
                        fnXor:   aluResult <= opA ^ opB;
                        fnSrl:   aluResult <= {1'b0, opA[dataWidth-1:1]};
                        default: ;                          // unknown func, keep value
                    endcase
                end
                opAddi: aluResult <= opA + immExt;
                opSubi: aluResult <= opA - immExt;
                // word offset, wraps within 12 bits
                opBeqz: branchTarget <= nextPc + {immExt[pcWidth-2:0], 1'b0};
                default: ;
            endcase
        end
    end

    // x ^ x registered in execute must read as zero one phase later
    xorSelfZero: assert property (@(posedge clock) disable iff (!rstN)
        (phase == phaseMemory && opcode == opAlu && func == fnXor &&
         instr.rFormat.src1 == instr.rFormat.src2) |-> aluResult == '0);

endmodule

// File: logic/registerFile.sv
// four-entry register file, R0 hard-wired to zero
// two asynchronous read ports, one synchronous write port
module registerFile (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [vsaPkg::regAddrWidth-1:0] readAddrA,
    input  logic [vsaPkg::regAddrWidth-1:0] readAddrB,
    output logic [vsaPkg::dataWidth-1:0]    readDataA,
    output logic [vsaPkg::dataWidth-1:0]    readDataB,
    input  logic                            writeEn,
    input  logic [vsaPkg::regAddrWidth-1:0] writeAddr,
    input  logic [vsaPkg::dataWidth-1:0]    writeData
);
    import vsaPkg::*;

    logic [dataWidth-1:0] regs [0:(1 << regAddrWidth)-1];

    // reads see the array directly, R0 forced to zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << regAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin    // R0 writes dropped
            regs[writeAddr] <= writeData;
        end
    end

    // entry zero never takes a write over the whole run
    r0Zero: assert property (@(posedge clock) disable iff (!rstN)
        regs[0] == '0);

endmodule

// File: logic/fetchUnit.sv
// phase sequencer and fetch stage
// holds pc, next-pc and the instruction register, updates pc once per instruction
module fetchUnit (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         takeBranch,
    input  logic [vsaPkg::pcWidth-1:0]   branchTarget,
    input  logic [vsaPkg::dataWidth-1:0] instruction,
    output vsaPkg::phaseT                phase,
    output logic [vsaPkg::pcWidth-1:0]   pc,
    output logic [vsaPkg::pcWidth-1:0]   nextPc,
    output vsaPkg::instrT                instr
);
    import vsaPkg::*;

    phaseT phaseNext;

    // wraps after write-back
    always_comb begin
        case (phase)
            phaseFetch:     phaseNext = phaseDecode;
            phaseDecode:    phaseNext = phaseExecute;
            phaseExecute:   phaseNext = phaseMemory;
            phaseMemory:    phaseNext = phaseWriteback;
            default:        phaseNext = phaseFetch;    // write-back and illegal codes
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            phase  <= phaseFetch;
            pc     <= '0;
            nextPc <= '0;
            instr  <= '0;
        end else begin
            phase <= phaseNext;
            if (phase == phaseFetch) begin
                instr  <= instruction;                  // IR load
                nextPc <= pc + pcWidth'(pcStep);        // sequential successor
            end
            // pc moves only here, once per five cycles
            if (phase == phaseMemory) begin
                pc <= takeBranch ? branchTarget : nextPc;
            end
        end
    end

    // phase stays within the five encodings
    phaseLegal: assert property (@(posedge clock) disable iff (!rstN)
        phase inside {phaseFetch, phaseDecode, phaseExecute, phaseMemory, phaseWriteback});

    // half-word alignment of pc and next-pc, branch targets included
    pcAligned: assert property (@(posedge clock) disable iff (!rstN)
        !pc[0] && !nextPc[0]);

endmodule

// File: logic/vsaPkg.sv
// shared definitions for the 16-bit multicycle core
// widths, opcodes, function codes, phase encoding and the instruction word
package vsaPkg;

    localparam int dataWidth    = 16;   // register and data bus width
    localparam int pcWidth      = 12;   // program counter width
    localparam int regAddrWidth = 2;    // R0..R3
    localparam int pcStep       = 2;    // bytes per instruction

    // opcodes, top three bits of every instruction
    localparam logic [2:0] opLw   = 3'd0;
    localparam logic [2:0] opSw   = 3'd1;
    localparam logic [2:0] opBeqz = 3'd2;
    localparam logic [2:0] opAlu  = 3'd3;   // R-format, func selects the operation
    localparam logic [2:0] opAddi = 3'd4;
    localparam logic [2:0] opSubi = 3'd5;

    // R-format function codes
    localparam logic [6:0] fnAdd = 7'd0;
    localparam logic [6:0] fnSub = 7'd1;
    localparam logic [6:0] fnAnd = 7'd2;
    localparam logic [6:0] fnOr  = 7'd3;
    localparam logic [6:0] fnXor = 7'd4;
    localparam logic [6:0] fnSrl = 7'd5;   // logical shift right by one

    // five phases per instruction, in this order
    typedef enum logic [2:0] {
        phaseFetch     = 3'd0,
        phaseDecode    = 3'd1,
        phaseExecute   = 3'd2,
        phaseMemory    = 3'd3,
        phaseWriteback = 3'd4
    } phaseT;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] src1;
        logic [1:0] src2;
        logic [1:0] dest;
        logic [6:0] func;
    } rFormatT;

    // dest here overlays src2 of the R view
    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] src1;
        logic [1:0] dest;
        logic [8:0] imm;    // signed
    } iFormatT;

    typedef union packed {
        rFormatT rFormat;   // opAlu only
        iFormatT iFormat;   // everything else
    } instrT;

endpackage
